// ==== logic/wb8_pkg.sv ====
package wb8_pkg;

    // request from the bus master
    typedef struct packed {
        logic [31:0] adr;
        logic [7:0]  dat;
        logic        we;
        logic        stb;
        logic        cyc;
    } wb_req_t;

    // response from a slave
    typedef struct packed {
        logic [7:0] dat;
        logic       ack;
    } wb_rsp_t;

    // address map, region in adr[31:28]
    localparam logic [3:0] IO_REGION = 4'hF;

    // slot within the I/O region, adr[27:24]
    // anything other than the SPI slot lands on the LEDs
    localparam logic [3:0] SPI_SLOT = 4'h1;

    // SPI register offsets in adr[1:0]
    localparam logic [1:0] SPI_REG_DATA   = 2'd0;
    localparam logic [1:0] SPI_REG_STATUS = 2'd1;
    localparam logic [1:0] SPI_REG_CTRL   = 2'd2;

endpackage

// ==== logic/wb8_reset_stretch.sv ====
module wb8_reset_stretch #(
    parameter int RESET_CYCLES = 16
) (
    input  logic clk,
    input  logic rst_n_i,
    output logic rst_o
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;

    // block RAM reads zeros for a while after config, keep the fabric quiet
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            rst_o <= 1'b1;
        end else if (cnt_q != CNT_W'(RESET_CYCLES)) begin
            cnt_q <= cnt_q + 1'b1;
            rst_o <= 1'b1;
        end else begin
            rst_o <= 1'b0;
        end
    end

endmodule

// ==== logic/wb8_addr_decode.sv ====
module wb8_addr_decode (
    input  wb8_pkg::wb_req_t req_i,
    input  wb8_pkg::wb_rsp_t ram_rsp_i,
    input  wb8_pkg::wb_rsp_t led_rsp_i,
    input  wb8_pkg::wb_rsp_t spi_rsp_i,
    output logic             ram_stb_o,
    output logic             led_stb_o,
    output logic             spi_stb_o,
    output wb8_pkg::wb_rsp_t rsp_o
);

    import wb8_pkg::*;

    logic bus_stb;
    logic sel_io;
    logic sel_spi;

    // a strobe only counts inside an active cycle
    assign bus_stb = req_i.stb & req_i.cyc;

    assign sel_io  = (req_i.adr[31:28] == IO_REGION);
    assign sel_spi = sel_io && (req_i.adr[27:24] == SPI_SLOT);

    always_comb begin
        ram_stb_o = 1'b0;
        led_stb_o = 1'b0;
        spi_stb_o = 1'b0;
        if (!sel_io) begin
            ram_stb_o = bus_stb;
            rsp_o     = ram_rsp_i;
        end else if (sel_spi) begin
            spi_stb_o = bus_stb;
            rsp_o     = spi_rsp_i;
        end else begin
            // every other I/O slot goes to the LEDs
            led_stb_o = bus_stb;
            rsp_o     = led_rsp_i;
        end
    end

endmodule

// ==== logic/wb8_ram.sv ====
module wb8_ram #(
    parameter int RAM_ADDR_W = 10
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             stb_i,
    input  wb8_pkg::wb_req_t req_i,
    output wb8_pkg::wb_rsp_t rsp_o
);

    localparam int DEPTH = 2 ** RAM_ADDR_W;

    logic [7:0]            mem [DEPTH];
    logic [RAM_ADDR_W-1:0] addr;
    logic [7:0]            rd_q;
    logic                  ack_q;
    logic                  first_cycle;

    // upper address bits are ignored, so the array aliases
    assign addr = req_i.adr[RAM_ADDR_W-1:0];

    // strobe cycle before the ack
    assign first_cycle = stb_i & ~ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            // ack_q blocks a second ack while stb is still up
            ack_q <= first_cycle;
        end
    end

    // no reset on the array or the read register
    always_ff @(posedge clk) begin
        if (first_cycle && req_i.we) begin
            mem[addr] <= req_i.dat;
        end
        if (first_cycle) begin
            rd_q <= mem[addr];
        end
    end

    assign rsp_o.dat = rd_q;
    assign rsp_o.ack = ack_q;

endmodule

// ==== logic/wb8_leds.sv ====
module wb8_leds (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             stb_i,
    input  wb8_pkg::wb_req_t req_i,
    output wb8_pkg::wb_rsp_t rsp_o,
    output logic [7:0]       leds_o
);

    logic [7:0] leds_q;
    logic       ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            leds_q <= 8'h00;
        end else begin
            ack_q <= stb_i & ~ack_q;
            // commit at the end of the ack cycle
            // so the pins change in the cycle after the ack
            if (stb_i && ack_q && req_i.we) begin
                leds_q <= req_i.dat;
            end
        end
    end

    assign leds_o    = leds_q;
    assign rsp_o.dat = leds_q;
    assign rsp_o.ack = ack_q;

endmodule

// ==== logic/wb8_spi.sv ====
module wb8_spi #(
    parameter int SPI_CLK_DIV = 2
) (
    input  logic             clk,
    input  logic             rst_i,
    input  logic             stb_i,
    input  wb8_pkg::wb_req_t req_i,
    output wb8_pkg::wb_rsp_t rsp_o,
    input  logic             spi_miso_i,
    output logic             spi_sclk_o,
    output logic             spi_mosi_o,
    output logic             spi_cs_n_o
);

    import wb8_pkg::*;

    localparam int DIV_W = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;

    logic             ack_q;
    logic             busy_q;
    logic             sclk_q;
    logic             mosi_q;
    logic             cs_n_q;
    logic [DIV_W-1:0] div_cnt_q;
    logic [2:0]       bit_cnt_q;
    logic [7:0]       shift_q;
    logic [7:0]       rx_q;

    logic [1:0] reg_sel;
    logic       wr_en;
    logic       start;
    logic       tick;
    logic       rise;
    logic       fall;
    logic       last;

    assign reg_sel = req_i.adr[1:0];
    assign wr_en   = stb_i & req_i.we & ~ack_q;

    // writes to the data register while busy are acked and dropped
    assign start = wr_en && (reg_sel == SPI_REG_DATA) && !busy_q;

    // half-period of sclk is SPI_CLK_DIV cycles
    assign tick = busy_q && (div_cnt_q == DIV_W'(SPI_CLK_DIV - 1));
    assign rise = tick & ~sclk_q;
    assign fall = tick & sclk_q;
    assign last = fall && (bit_cnt_q == 3'd7);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q     <= 1'b0;
            busy_q    <= 1'b0;
            sclk_q    <= 1'b0;
            mosi_q    <= 1'b0;
            cs_n_q    <= 1'b1;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else begin
            ack_q <= stb_i & ~ack_q;
            if (wr_en && (reg_sel == SPI_REG_CTRL)) begin
                cs_n_q <= req_i.dat[0];
            end
            if (start) begin
                busy_q    <= 1'b1;
                sclk_q    <= 1'b0;
                div_cnt_q <= '0;
                bit_cnt_q <= '0;
                // mode 0, first bit set up before the first rising edge
                mosi_q    <= req_i.dat[7];
            end else if (busy_q) begin
                if (tick) begin
                    div_cnt_q <= '0;
                    sclk_q    <= ~sclk_q;
                end else begin
                    div_cnt_q <= div_cnt_q + 1'b1;
                end
                if (fall) begin
                    // next bit goes out on the falling edge
                    mosi_q    <= shift_q[7];
                    bit_cnt_q <= bit_cnt_q + 1'b1;
                end
                if (last) begin
                    busy_q <= 1'b0;
                end
            end
        end
    end

    // shifter and receive byte
    always_ff @(posedge clk) begin
        if (start) begin
            shift_q <= req_i.dat;
        end else if (rise) begin
            // miso sampled on the rising edge
            shift_q <= {shift_q[6:0], spi_miso_i};
        end
        if (last) begin
            rx_q <= shift_q;
        end
    end

    always_comb begin
        case (reg_sel)
            SPI_REG_DATA:   rsp_o.dat = rx_q;
            SPI_REG_STATUS: rsp_o.dat = {7'd0, busy_q};
            SPI_REG_CTRL:   rsp_o.dat = {7'd0, cs_n_q};
            default:        rsp_o.dat = 8'h00;
        endcase
    end

    assign rsp_o.ack  = ack_q;
    assign spi_sclk_o = sclk_q;
    assign spi_mosi_o = mosi_q;
    assign spi_cs_n_o = cs_n_q;

endmodule

// ==== logic/wb8_fabric_top.sv ====
module wb8_fabric_top #(
    parameter int RAM_ADDR_W   = 10,
    parameter int RESET_CYCLES = 16,
    parameter int SPI_CLK_DIV  = 2
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  wb8_pkg::wb_req_t bus_req_i,
    output wb8_pkg::wb_rsp_t bus_rsp_o,
    output logic [7:0]       leds_o,
    input  logic             spi_miso_i,
    output logic             spi_sclk_o,
    output logic             spi_mosi_o,
    output logic             spi_cs_n_o
);

    import wb8_pkg::*;

    // active high reset for the whole fabric
    logic    fabric_rst;
    logic    ram_stb;
    logic    led_stb;
    logic    spi_stb;
    wb_rsp_t ram_rsp;
    wb_rsp_t led_rsp;
    wb_rsp_t spi_rsp;

    wb8_reset_stretch #(
        .RESET_CYCLES(RESET_CYCLES)
    ) i_reset (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .rst_o  (fabric_rst)
    );

    wb8_addr_decode i_decode (
        .req_i    (bus_req_i),
        .ram_rsp_i(ram_rsp),
        .led_rsp_i(led_rsp),
        .spi_rsp_i(spi_rsp),
        .ram_stb_o(ram_stb),
        .led_stb_o(led_stb),
        .spi_stb_o(spi_stb),
        .rsp_o    (bus_rsp_o)
    );

    wb8_ram #(
        .RAM_ADDR_W(RAM_ADDR_W)
    ) i_ram (
        .clk  (clk),
        .rst_i(fabric_rst),
        .stb_i(ram_stb),
        .req_i(bus_req_i),
        .rsp_o(ram_rsp)
    );

    wb8_leds i_leds (
        .clk   (clk),
        .rst_i (fabric_rst),
        .stb_i (led_stb),
        .req_i (bus_req_i),
        .rsp_o (led_rsp),
        .leds_o(leds_o)
    );

    wb8_spi #(
        .SPI_CLK_DIV(SPI_CLK_DIV)
    ) i_spi (
        .clk       (clk),
        .rst_i     (fabric_rst),
        .stb_i     (spi_stb),
        .req_i     (bus_req_i),
        .rsp_o     (spi_rsp),
        .spi_miso_i(spi_miso_i),
        .spi_sclk_o(spi_sclk_o),
        .spi_mosi_o(spi_mosi_o),
        .spi_cs_n_o(spi_cs_n_o)
    );

endmodule

// ==== test/tb_clock.sv ====
module tb_clock #(
    parameter int PERIOD = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== test/tb_checker.sv ====
module tb_checker #(
    parameter int RESET_CYCLES = 16,
    parameter int MAX_POLLS    = 16,
    parameter int SCLK_RISES   = 64
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  wb8_pkg::wb_req_t req_i,
    input  wb8_pkg::wb_rsp_t rsp_i,
    input  logic [7:0]       leds_i,
    input  logic             spi_sclk_i,
    input  logic             spi_cs_n_i,
    input  logic             exp_chk_i,
    input  logic [7:0]       exp_dat_i,
    input  logic [7:0]       exp_leds_i,
    input  logic             exp_cs_n_i,
    input  logic             done_i,
    output int               err_cnt_o
);

    import wb8_pkg::*;

    int   low_cnt    = 0;
    int   rel_cnt    = 0;
    int   wait_cnt   = 0;
    int   busy_run   = 0;
    int   sclk_rises = 0;
    int   mismatches = 0;
    int   faults     = 0;
    logic reported   = 1'b0;
    logic sclk_prev  = 1'b0;
    logic ready;
    logic in_reset;
    logic live;
    logic status_rd;

    // outputs settle after two edges with rst_n_i low
    assign ready     = (low_cnt >= 2);
    assign in_reset  = ready && (rel_cnt <= RESET_CYCLES);
    assign live      = ready && (rel_cnt > RESET_CYCLES);
    assign status_rd = rsp_i.ack && !req_i.we && (req_i.adr[31:28] == IO_REGION)
                       && (req_i.adr[27:24] == SPI_SLOT) && (req_i.adr[1:0] == SPI_REG_STATUS);
    assign err_cnt_o = mismatches + faults;

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        mismatches++;
        $display("Mismatch %s at %0t: got %h, expected %h", name, $time, got, exp);
    endtask

    task automatic report_fault(input string msg);
        faults++;
        $display("error at %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (!rst_n_i) begin
            low_cnt <= (low_cnt < 2) ? low_cnt + 1 : low_cnt;
            rel_cnt <= 0;
        end else if (rel_cnt <= RESET_CYCLES) begin
            rel_cnt <= rel_cnt + 1;
        end
        // eight sclk periods per transfer
        sclk_prev <= spi_sclk_i;
        if (ready && spi_sclk_i === 1'b1 && sclk_prev === 1'b0) begin
            sclk_rises <= sclk_rises + 1;
        end
        if (in_reset && rsp_i.ack !== 1'b0) begin
            report_fault("ack returned while the fabric is still held in reset");
        end
        if (in_reset && spi_cs_n_i !== 1'b1) begin
            report_mismatch("spi_cs_n_o", {7'd0, spi_cs_n_i}, 8'h01);
        end
        if (in_reset && spi_sclk_i !== 1'b0) begin
            report_mismatch("spi_sclk_o", {7'd0, spi_sclk_i}, 8'h00);
        end
        if (ready && leds_i !== exp_leds_i) begin
            report_mismatch("leds_o", leds_i, exp_leds_i);
        end
        if (live) begin
            if (req_i.stb && req_i.cyc && rsp_i.ack !== 1'b1) begin
                wait_cnt <= wait_cnt + 1;
                if (wait_cnt == 2) begin
                    report_fault($sformatf("no ack within 2 cycles for adr %h", req_i.adr));
                end
            end else begin
                wait_cnt <= 0;
            end
            if (rsp_i.ack && exp_chk_i && !req_i.we && rsp_i.dat !== exp_dat_i) begin
                report_mismatch($sformatf("bus_rsp_o.dat (adr %h)", req_i.adr),
                                rsp_i.dat, exp_dat_i);
            end
            // chip select only compared between accesses
            if (!req_i.stb && spi_cs_n_i !== exp_cs_n_i) begin
                report_mismatch("spi_cs_n_o", {7'd0, spi_cs_n_i}, {7'd0, exp_cs_n_i});
            end
            if (status_rd) begin
                busy_run <= rsp_i.dat[0] ? busy_run + 1 : 0;
                if (rsp_i.dat[0] && busy_run + 1 == MAX_POLLS) begin
                    report_fault("SPI busy bit never cleared while polling the status register");
                end
            end
        end
        if (done_i && !reported) begin
            reported <= 1'b1;
            if (sclk_rises != SCLK_RISES) begin
                report_mismatch("spi_sclk_o rising edges", 8'(sclk_rises), 8'(SCLK_RISES));
            end
            $display("checker summary: %0d errors (%0d mismatches, %0d other failures)",
                     mismatches + faults, mismatches, faults);
        end
    end

endmodule

// ==== test/wb8_fabric_asserts.sv ====
module wb8_fabric_asserts (
    input logic clk,
    input logic rst_n_i,
    input logic fabric_rst_i,
    input logic ack_i,
    input logic spi_cs_n_i
);

    // ack is a single-cycle pulse
    ack_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n_i) ack_i |=> !ack_i
    ) else $error("ack stayed high for two cycles in a row");

    // first reset cycle may still show an ack from before the reset
    no_ack_in_reset: assert property (
        @(posedge clk) ($past(fabric_rst_i) && fabric_rst_i) |-> !ack_i
    ) else $error("ack given while the internal reset is active");

    cs_idle_after_reset: assert property (
        @(posedge clk) $fell(fabric_rst_i) |-> spi_cs_n_i
    ) else $error("spi chip select not deasserted right after reset");

endmodule

bind wb8_fabric_top wb8_fabric_asserts i_asserts (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .fabric_rst_i(fabric_rst),
    .ack_i       (bus_rsp_o.ack),
    .spi_cs_n_i  (spi_cs_n_o)
);

// ==== test/tb_wb8_fabric.sv ====
module tb_wb8_fabric;

    import wb8_pkg::*;

    localparam int RAM_ADDR_W   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int SPI_CLK_DIV  = 2;
    localparam int N_RAM        = 64;
    localparam int N_ALIAS      = 8;
    localparam int N_LED        = 4;
    localparam int N_SPI        = 8;
    localparam int MAX_POLLS    = 4 * SPI_CLK_DIV + 8;
    // reset window, ram with re-read, alias, leds with decode writes, spi
    localparam int N_ACCESS = 1 + 3 * N_RAM + N_ALIAS + 3 * N_LED + 3 + N_SPI * (2 + MAX_POLLS);
    localparam int TIMEOUT  = N_ACCESS * 40 + 200;
    localparam logic [31:0] SPI_BASE = {IO_REGION, SPI_SLOT, 24'h0};

    logic        clk;
    logic        rst_n;
    wb_req_t     bus_req;
    wb_rsp_t     bus_rsp;
    logic [7:0]  leds;
    logic        spi_sclk;
    logic        spi_mosi;
    logic        spi_cs_n;
    logic        exp_chk;
    logic [7:0]  exp_dat;
    logic [7:0]  exp_leds;
    logic        exp_cs_n;
    logic        done;
    int          err_cnt;
    int          cycles = 0;
    integer      seed   = 32'hb2d3c81d;
    logic [7:0]  ram_model [int];
    logic [7:0]  led_model = 8'h00;
    logic [7:0]  rx_model  = 8'h00;
    logic        cs_model  = 1'b1;
    logic [31:0] ram_addrs [$];

    tb_clock #(.PERIOD(4)) i_clock (.clk_o(clk));

    // miso tied back to mosi
    wb8_fabric_top #(
        .RAM_ADDR_W  (RAM_ADDR_W),
        .RESET_CYCLES(RESET_CYCLES),
        .SPI_CLK_DIV (SPI_CLK_DIV)
    ) i_dut (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .bus_req_i (bus_req),
        .bus_rsp_o (bus_rsp),
        .leds_o    (leds),
        .spi_miso_i(spi_mosi),
        .spi_sclk_o(spi_sclk),
        .spi_mosi_o(spi_mosi),
        .spi_cs_n_o(spi_cs_n)
    );

    tb_checker #(
        .RESET_CYCLES(RESET_CYCLES),
        .MAX_POLLS   (MAX_POLLS),
        .SCLK_RISES  (8 * N_SPI)
    ) i_checker (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .req_i     (bus_req),
        .rsp_i     (bus_rsp),
        .leds_i    (leds),
        .spi_sclk_i(spi_sclk),
        .spi_cs_n_i(spi_cs_n),
        .exp_chk_i (exp_chk),
        .exp_dat_i (exp_dat),
        .exp_leds_i(exp_leds),
        .exp_cs_n_i(exp_cs_n),
        .done_i    (done),
        .err_cnt_o (err_cnt)
    );

    // expected read data from the address map and the reference state
    function automatic logic [7:0] expected_read(input logic [31:0] adr);
        if (adr[31:28] != IO_REGION) begin
            return ram_model[int'(adr[RAM_ADDR_W-1:0])];
        end
        if (adr[27:24] != SPI_SLOT) begin
            return led_model;
        end
        case (adr[1:0])
            SPI_REG_DATA: return rx_model;
            SPI_REG_CTRL: return {7'd0, cs_model};
            default:      return 8'h00;
        endcase
    endfunction

    function automatic void model_write(input logic [31:0] adr, input logic [7:0] dat);
        if (adr[31:28] != IO_REGION) begin
            ram_model[int'(adr[RAM_ADDR_W-1:0])] = dat;
        end else if (adr[27:24] != SPI_SLOT) begin
            led_model = dat;
        end else if (adr[1:0] == SPI_REG_DATA) begin
            // the loopback returns the byte that was sent
            rx_model = dat;
        end else if (adr[1:0] == SPI_REG_CTRL) begin
            cs_model = dat[0];
        end
    endfunction

    task automatic bus_access(input logic [31:0] adr, input logic [7:0] dat, input logic we,
                              input logic chk, output logic [7:0] rdat);
        @(posedge clk);
        bus_req <= {adr, dat, we, 2'b11};
        exp_chk <= chk;
        exp_dat <= expected_read(adr);
        @(posedge clk);
        while (bus_rsp.ack !== 1'b1) begin
            @(posedge clk);
        end
        rdat = bus_rsp.dat;
        bus_req.stb <= 1'b0;
        bus_req.cyc <= 1'b0;
        exp_chk     <= 1'b0;
    endtask

    task automatic bus_write(input logic [31:0] adr, input logic [7:0] dat);
        logic [7:0] ignored_dat;
        bus_access(adr, dat, 1'b1, 1'b0, ignored_dat);
        model_write(adr, dat);
        exp_leds <= led_model;
        exp_cs_n <= cs_model;
    endtask

    task automatic bus_read(input logic [31:0] adr, output logic [7:0] rdat);
        bus_access(adr, 8'h00, 1'b0, 1'b1, rdat);
    endtask

    initial begin
        logic [31:0] adr;
        logic [7:0]  dat;
        logic [7:0]  rdat;
        int          idx;
        int          polls;

        rst_n    = 1'b0;
        bus_req  = '0;
        exp_chk  = 1'b0;
        exp_dat  = 8'h00;
        exp_leds = 8'h00;
        exp_cs_n = 1'b1;
        done     = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // LED write held through the stretched reset, no ack and no effect
        bus_req <= {32'hF000_0000, 8'hFF, 3'b111};
        repeat (RESET_CYCLES - 4) @(posedge clk);
        bus_req <= '0;
        repeat (6) @(posedge clk);

        for (int i = 0; i < N_RAM; i++) begin
            adr = $random(seed);
            if (adr[31:28] == IO_REGION) begin
                adr[31] = 1'b0;
            end
            dat = $random(seed);
            ram_addrs.push_back(adr);
            bus_write(adr, dat);
            idx = {$random(seed)} % (i + 1);
            bus_read(ram_addrs[idx], rdat);
        end
        // bits above the array index alias
        for (int i = 0; i < N_ALIAS; i++) begin
            bus_read(ram_addrs[i] ^ (32'h1 << (RAM_ADDR_W + 2 * i)), rdat);
        end

        // every slot but the SPI one reaches the LED register
        for (int i = 0; i < N_LED; i++) begin
            adr = {IO_REGION, 4'(i * 5), 24'($random(seed))};
            bus_write(adr, $random(seed));
            bus_read(adr, rdat);
        end

        bus_write(SPI_BASE + 32'(SPI_REG_CTRL), 8'h00);
        bus_read(SPI_BASE + 32'(SPI_REG_CTRL), rdat);
        for (int i = 0; i < N_SPI; i++) begin
            bus_write(SPI_BASE + 32'(SPI_REG_DATA), $random(seed));
            polls = 0;
            rdat  = 8'h01;
            while (rdat[0] && polls <= MAX_POLLS) begin
                bus_access(SPI_BASE + 32'(SPI_REG_STATUS), 8'h00, 1'b0, 1'b0, rdat);
                polls++;
            end
            bus_read(SPI_BASE + 32'(SPI_REG_DATA), rdat);
        end
        bus_write(SPI_BASE + 32'(SPI_REG_CTRL), 8'h01);

        // I/O writes sharing low address bits with RAM must not touch it
        for (int i = 0; i < N_LED; i++) begin
            bus_write({IO_REGION, 4'h3, ram_addrs[i][23:0]}, $random(seed));
        end
        for (int i = 0; i < N_RAM; i++) begin
            bus_read(ram_addrs[i], rdat);
        end

        done <= 1'b1;
        repeat (2) @(posedge clk);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

endmodule

// ==== wb8_fabric.f ====
logic/wb8_pkg.sv
logic/wb8_reset_stretch.sv
logic/wb8_addr_decode.sv
logic/wb8_ram.sv
logic/wb8_leds.sv
logic/wb8_spi.sv
logic/wb8_fabric_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/wb8_fabric_asserts.sv
test/tb_wb8_fabric.sv

// ==== Bender.yml ====
package:
  name: wb8_fabric

sources:
  - logic/wb8_pkg.sv
  - logic/wb8_reset_stretch.sv
  - logic/wb8_addr_decode.sv
  - logic/wb8_ram.sv
  - logic/wb8_leds.sv
  - logic/wb8_spi.sv
  - logic/wb8_fabric_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/tb_checker.sv
      - test/wb8_fabric_asserts.sv
      - test/tb_wb8_fabric.sv
